// File: design/ball_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ball_bus_if
    import ball_pkg::*;
();

    logic        active;            // Ball in play
    ball_index_t index;             // Slot of the active ball
    ball_t       ball;
    logic        landed;            // Pulse on the landing cycle

    modport source (
        output active,
        output index,
        output ball,
        output landed
    );

    modport sink (
        input active,
        input index,
        input ball,
        input landed
    );

endinterface

`default_nettype wire

// File: design/ball_drop_consts.svh
`ifndef BALL_DROP_CONSTS_SVH
`define BALL_DROP_CONSTS_SVH

// Widths
`define COORD_W      12
`define IDX_W        4

`define NUM_BALLS    10

// Board geometry in pixels
`define BOARD_LEFT   10
`define BOARD_RIGHT  330
`define BOARD_TOP    40
`define BOARD_FLOOR  240
`define START_X      170            // Spawn column of every ball

`define FALL_STEP    3              // Pixels per cycle while falling

// Ball radii
`define SIZE_S       5
`define SIZE_M       10
`define SIZE_L       15
`define SIZE_XL      20

`endif

// File: design/ball_drop_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ball_drop_consts.svh"

module ball_drop_top
    import ball_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 falling,
    input  wire                 left,
    input  wire                 right,
    input  wire  [`IDX_W-1:0]   read_index,
    output logic [`COORD_W-1:0] read_x,
    output logic [`COORD_W-1:0] read_y,
    output logic [`COORD_W-1:0] read_size,
    output logic                finish
);

    ball_t slot_balls [`NUM_BALLS];

    ball_bus_if bus_if ();

    drop_control u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .falling (falling),
        .left    (left),
        .right   (right),
        .bus     (bus_if.source),
        .finish  (finish)
    );

    // One storage slot per ball in the sequence
    genvar i;
    generate
        for (i = 0; i < `NUM_BALLS; i++) begin : g_slot
            ball_slot #(
                .SLOT_ID (i)
            ) u_slot (
                .clk  (clk),
                .rst  (rst),
                .bus  (bus_if.sink),
                .ball (slot_balls[i])
            );
        end
    endgenerate

    board_readout u_readout (
        .clk        (clk),
        .rst        (rst),
        .slot_balls (slot_balls),
        .read_index (read_index),
        .read_x     (read_x),
        .read_y     (read_y),
        .read_size  (read_size)
    );

endmodule

`default_nettype wire

// File: design/ball_pkg.sv
`default_nettype none

`include "ball_drop_consts.svh"

package ball_pkg;

    typedef logic [`COORD_W-1:0] coord_t;
    typedef logic [`IDX_W-1:0]   ball_index_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t size;
    } ball_t;

    // Fixed play order of ball sizes
    function automatic coord_t ball_size_of(input ball_index_t num);
        case (num)
            0:       return coord_t'(`SIZE_S);
            1:       return coord_t'(`SIZE_M);
            2:       return coord_t'(`SIZE_L);
            3:       return coord_t'(`SIZE_L);
            4:       return coord_t'(`SIZE_S);
            5:       return coord_t'(`SIZE_M);
            6:       return coord_t'(`SIZE_L);
            7:       return coord_t'(`SIZE_XL);
            8:       return coord_t'(`SIZE_M);
            9:       return coord_t'(`SIZE_L);
            default: return '0;         // No ball past the last one
        endcase
    endfunction

endpackage

`default_nettype wire

// File: design/ball_slot.sv
`timescale 1ns/1ps
`default_nettype none

module ball_slot
    import ball_pkg::*;
#(
    parameter int SLOT_ID = 0
) (
    input  wire      clk,
    input  wire      rst,
    ball_bus_if.sink bus,
    output ball_t    ball
);

    logic selected;
    logic sealed;                   // Set once this slot's ball has landed

    assign selected = bus.active && !sealed && (bus.index == ball_index_t'(SLOT_ID));

    always_ff @(posedge clk) begin
        if (rst) begin
            ball   <= '0;
            sealed <= 1'b0;
        end else if (selected) begin
            ball   <= bus.ball;     // Follow the live ball
            sealed <= bus.landed;
        end
    end

endmodule

`default_nettype wire

// File: design/board_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "ball_drop_consts.svh"

module board_readout
    import ball_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire ball_t  slot_balls [`NUM_BALLS],
    input  wire         [`IDX_W-1:0] read_index,
    output coord_t      read_x,
    output coord_t      read_y,
    output coord_t      read_size
);

    ball_index_t sel;

    assign sel = read_index;

    always_ff @(posedge clk) begin
        if (rst) begin
            read_x    <= '0;
            read_y    <= '0;
            read_size <= '0;
        end else if (sel < ball_index_t'(`NUM_BALLS)) begin
            read_x    <= slot_balls[sel].x;
            read_y    <= slot_balls[sel].y;
            read_size <= slot_balls[sel].size;
        end else begin
            read_x    <= '0;        // Out of range reads empty
            read_y    <= '0;
            read_size <= '0;
        end
    end

endmodule

`default_nettype wire

// File: design/drop_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "ball_drop_consts.svh"

module drop_control
    import ball_pkg::*;
    import drop_ctrl_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       falling,
    input  wire       left,
    input  wire       right,
    ball_bus_if.source bus,
    output logic      finish
);

    drop_state_t state;
    drop_state_t state_nxt;
    coord_t      x_pos;
    coord_t      x_nxt;
    coord_t      y_pos;
    coord_t      y_nxt;
    ball_index_t idx;
    ball_index_t idx_nxt;
    coord_t      size;
    coord_t      rest_y;

    assign size   = ball_size_of(idx);
    assign rest_y = coord_t'(`BOARD_FLOOR) - size;     // Resting height on the floor

    always_comb begin
        state_nxt = state;
        x_nxt     = x_pos;
        y_nxt     = y_pos;
        idx_nxt   = idx;

        case (state)
            SELECT: begin
                if (falling) begin
                    state_nxt = FALLING;
                end else if (left) begin                // Left wins over right
                    if (x_pos != coord_t'(`BOARD_LEFT) + size) begin
                        x_nxt = x_pos - 1'b1;
                    end
                end else if (right) begin
                    if (x_pos != coord_t'(`BOARD_RIGHT) - size) begin
                        x_nxt = x_pos + 1'b1;
                    end
                end
            end

            FALLING: begin
                if (y_pos == rest_y) begin
                    state_nxt = LANDED;
                end else if (y_pos + coord_t'(`FALL_STEP) >= rest_y) begin
                    y_nxt = rest_y;                     // Last step is clamped
                end else begin
                    y_nxt = y_pos + coord_t'(`FALL_STEP);
                end
            end

            LANDED: begin
                if (idx == ball_index_t'(`NUM_BALLS - 1)) begin
                    state_nxt = DONE;
                end else begin
                    // Next ball respawns at the top
                    state_nxt = SELECT;
                    idx_nxt   = idx + 1'b1;
                    x_nxt     = coord_t'(`START_X);
                    y_nxt     = coord_t'(`BOARD_TOP) - ball_size_of(idx_nxt);
                end
            end

            default: begin
                state_nxt = DONE;                       // Inputs ignored
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SELECT;
            idx   <= '0;
            x_pos <= coord_t'(`START_X);
            y_pos <= coord_t'(`BOARD_TOP) - ball_size_of('0);
        end else begin
            state <= state_nxt;
            idx   <= idx_nxt;
            x_pos <= x_nxt;
            y_pos <= y_nxt;
        end
    end

    assign bus.active = (state != DONE);
    assign bus.index  = idx;
    assign bus.ball   = '{x: x_pos, y: y_pos, size: size};
    assign bus.landed = (state == LANDED);

    assign finish = (state == DONE);

endmodule

`default_nettype wire

// File: design/drop_ctrl_pkg.sv
`default_nettype none

package drop_ctrl_pkg;

    typedef enum logic [1:0] {
        SELECT  = 2'd0,             // Steering along the spawn row
        FALLING = 2'd1,
        LANDED  = 2'd2,             // Single cycle on the floor
        DONE    = 2'd3              // All balls played
    } drop_state_t;

endpackage

`default_nettype wire

// File: dv/tb_ball_drop.sv
`timescale 1ns/1ps
`default_nettype none

`include "ball_drop_consts.svh"

module tb_ball_drop;

    localparam int LAND_TIMEOUT   = 500;
    localparam int FINISH_TIMEOUT = 50;

    logic                clk;
    logic                rst;
    logic                falling;
    logic                left;
    logic                right;
    logic [`IDX_W-1:0]   read_index;
    logic [`COORD_W-1:0] read_x;
    logic [`COORD_W-1:0] read_y;
    logic [`COORD_W-1:0] read_size;
    logic                finish;

    logic [31:0] lfsr_state;
    int          move_dir[$];       // Bit 0 left, bit 1 right
    int          move_len[$];
    int          exp_x[`NUM_BALLS];
    int          exp_y[`NUM_BALLS];
    int          exp_size[`NUM_BALLS];

    ball_drop_top UUT (
        .clk        (clk),
        .rst        (rst),
        .falling    (falling),
        .left       (left),
        .right      (right),
        .read_index (read_index),
        .read_x     (read_x),
        .read_y     (read_y),
        .read_size  (read_size),
        .finish     (finish)
    );

    always #50 clk = ~clk;

    // Ball radius in play order
    function automatic int size_for_ball(input int num);
        case (num)
            0, 4:       return `SIZE_S;
            1, 5, 8:    return `SIZE_M;
            2, 3, 6, 9: return `SIZE_L;
            7:          return `SIZE_XL;
            default:    return 0;
        endcase
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // Landing point as {x, y} with the walls clamping every steering cycle
    function automatic logic [31:0] ref_landing(input int ball_num, input int n_moves);
        int x;
        int y;
        int sz;
        int m;
        int c;
        sz = size_for_ball(ball_num);
        x  = `START_X;
        for (m = 0; m < n_moves; m++) begin
            for (c = 0; c < move_len[m]; c++) begin
                if ((move_dir[m] & 1) != 0) begin           // Left wins
                    if (x != `BOARD_LEFT + sz) begin
                        x = x - 1;
                    end
                end else if ((move_dir[m] & 2) != 0) begin
                    if (x != `BOARD_RIGHT - sz) begin
                        x = x + 1;
                    end
                end
            end
        end
        y = `BOARD_FLOOR - sz;
        return {x[15:0], y[15:0]};
    endfunction

    task automatic take_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | lfsr_state[0];
        end
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Finished with errors");
        $fatal(1, "Stopping on timeout");
    endtask

    // One assignment per clock, so the DUT sees the move for len cycles
    task automatic play_move(input int dir, input int len);
        move_dir.push_back(dir);
        move_len.push_back(len);
        repeat (len) begin
            @(posedge clk);
            left  <= (dir & 1) != 0;
            right <= (dir & 2) != 0;
        end
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        left    <= 1'b0;
        right   <= 1'b0;
        falling <= 1'b0;
    endtask

    task automatic read_slot(input int k, output int x, output int y, output int s);
        @(posedge clk);
        read_index <= k[`IDX_W-1:0];
        @(posedge clk);                 // Readout registers one cycle later
        @(negedge clk);
        x = read_x;
        y = read_y;
        s = read_size;
    endtask

    task automatic check_slot(input int k);
        int x;
        int y;
        int s;
        read_slot(k, x, y, s);
        check_value($sformatf("slot %0d x", k), exp_x[k], x);
        check_value($sformatf("slot %0d y", k), exp_y[k], y);
        check_value($sformatf("slot %0d size", k), exp_size[k], s);
    endtask

    task automatic wait_for_landing(input int b);
        int   cycles;
        int   rest;
        logic seen;
        rest = `BOARD_FLOOR - size_for_ball(b);
        @(posedge clk);
        read_index <= b[`IDX_W-1:0];
        @(posedge clk);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < LAND_TIMEOUT) begin
            @(negedge clk);
            if (read_y == rest) begin
                seen = 1'b1;
            end
            cycles++;
        end
        if (!seen) begin
            fail_timeout($sformatf("ball %0d to land", b));
        end
    endtask

    task automatic wait_for_finish();
        int cycles;
        cycles = 0;
        while (!finish && cycles < FINISH_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!finish) begin
            fail_timeout("finish after the last ball");
        end
    endtask

    initial begin
        int          b;
        int          k;
        int          m;
        int          n_rand;
        int          dir;
        int          len;
        int          x;
        int          y;
        int          s;
        logic [31:0] landing;

        clk        = 1'b0;
        rst        = 1'b1;
        falling    = 1'b0;
        left       = 1'b0;
        right      = 1'b0;
        read_index = '0;
        lfsr_state = 32'hadae8eeb;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("finish after reset", 0, finish);

        // Slot 0 follows the first ball as soon as reset ends
        read_slot(0, x, y, s);
        check_value("spawn x", `START_X, x);
        check_value("spawn y", `BOARD_TOP - `SIZE_S, y);
        check_value("spawn size", `SIZE_S, s);
        for (k = 1; k < `NUM_BALLS; k++) begin
            read_slot(k, x, y, s);
            check_value($sformatf("reset slot %0d x", k), 0, x);
            check_value($sformatf("reset slot %0d y", k), 0, y);
            check_value($sformatf("reset slot %0d size", k), 0, s);
        end

        for (b = 0; b < `NUM_BALLS; b++) begin
            move_dir.delete();
            move_len.delete();
            if (b == 1) begin
                play_move(1, 180);                          // Into the left wall
            end
            if (b == 3) begin
                play_move(3, 40);                           // Both held steers left
                idle_inputs();
                read_slot(3, x, y, s);
                check_value("both held x", `START_X - 40, x);
            end
            if (b == 5) begin
                play_move(2, 180);                          // Into the right wall
            end
            if (b == 8) begin
                play_move(3, 200);
            end
            take_bits(2, n_rand);
            for (m = 0; m < n_rand + 2; m++) begin
                take_bits(2, dir);
                take_bits(7, len);
                play_move(dir, len + 1);
            end
            idle_inputs();

            landing = ref_landing(b, move_dir.size());
            read_slot(b, x, y, s);
            check_value($sformatf("ball %0d steered x", b), landing[31:16], x);

            @(posedge clk);
            falling <= 1'b1;
            @(posedge clk);
            falling <= 1'b0;
            wait_for_landing(b);

            exp_x[b]    = landing[31:16];
            exp_y[b]    = landing[15:0];
            exp_size[b] = size_for_ball(b);
            for (k = 0; k <= b; k++) begin
                check_slot(k);                              // Earlier slots must hold
            end
        end

        wait_for_finish();

        // DONE ignores everything
        repeat (64) begin
            take_bits(3, dir);
            @(posedge clk);
            left    <= (dir & 1) != 0;
            right   <= (dir & 2) != 0;
            falling <= (dir & 4) != 0;
            @(negedge clk);
            check_value("finish held", 1, finish);
        end
        idle_inputs();
        for (k = 0; k < `NUM_BALLS; k++) begin
            check_slot(k);
        end
        check_value("finish at end", 1, finish);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/ball_pkg.sv
design/drop_ctrl_pkg.sv
design/ball_bus_if.sv
design/drop_control.sv
design/ball_slot.sv
design/board_readout.sv
design/ball_drop_top.sv
dv/tb_ball_drop.sv
